// File: hdl/alu_int.sv
`include "exu_cfg.svh"

module alu_int (
    input  logic [`EXU_OP_W-1:0]    operator,
    input  logic [`EXU_DATA_W-1:0]  operand1,
    input  logic [`EXU_DATA_W-1:0]  operand2,
    output logic [`EXU_DATA_W-1:0]  alu_result,
    output logic                    overflow
);

    localparam int MSB = `EXU_DATA_W - 1;

    logic                       is_sub;
    logic [`EXU_DATA_W-1:0]     operand2_mux;
    logic [`EXU_DATA_W-1:0]     sum;
    logic [`EXU_SHAMT_W-1:0]    shamt;
    logic                       add_ovf;
    logic                       sub_ovf;
    logic                       less_signed;
    logic                       less_unsigned;

    function automatic logic [`EXU_DATA_W-1:0] lead_zeros(input logic [`EXU_DATA_W-1:0] v);
        logic [`EXU_DATA_W-1:0] cnt;
        logic                   found;
        cnt = '0;
        found = 1'b0;
        for (int i = MSB; i >= 0; i--) begin
            if (v[i]) begin
                found = 1'b1;
            end else if (!found) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    assign is_sub = (operator == `EXU_OP_SUB) || (operator == `EXU_OP_SUBU)
        || (operator == `EXU_OP_SLT);

    assign operand2_mux = is_sub ? (~operand2 + 1'b1) : operand2;   // Two's complement negate
    assign sum = operand1 + operand2_mux;

    // Sign checks use the original operand2 so that negating the most negative value is covered
    assign add_ovf = (operand1[MSB] == operand2[MSB]) && (sum[MSB] != operand1[MSB]);
    assign sub_ovf = (operand1[MSB] != operand2[MSB]) && (sum[MSB] != operand1[MSB]);

    assign overflow = ((operator == `EXU_OP_ADD || operator == `EXU_OP_ADDI) && add_ovf)
        || (operator == `EXU_OP_SUB && sub_ovf);

    // Equal signs cannot overflow, so the difference sign decides
    assign less_signed = (operand1[MSB] && !operand2[MSB])
        || ((operand1[MSB] == operand2[MSB]) && sum[MSB]);
    assign less_unsigned = (operand1 < operand2);

    assign shamt = operand1[`EXU_SHAMT_W-1:0];

    always_comb begin
        case (operator)
            `EXU_OP_AND:    alu_result = operand1 & operand2;
            `EXU_OP_OR:     alu_result = operand1 | operand2;
            `EXU_OP_NOR:    alu_result = ~(operand1 | operand2);
            `EXU_OP_XOR:    alu_result = operand1 ^ operand2;
            `EXU_OP_SLL:    alu_result = operand2 << shamt;
            `EXU_OP_SRL:    alu_result = operand2 >> shamt;
            `EXU_OP_SRA:    alu_result = $unsigned($signed(operand2) >>> shamt);
            `EXU_OP_ADD, `EXU_OP_ADDU, `EXU_OP_ADDI, `EXU_OP_ADDIU,
            `EXU_OP_SUB, `EXU_OP_SUBU: begin
                alu_result = sum;
            end
            `EXU_OP_SLT:    alu_result = {{MSB{1'b0}}, less_signed};
            `EXU_OP_SLTU:   alu_result = {{MSB{1'b0}}, less_unsigned};
            `EXU_OP_CLZ:    alu_result = lead_zeros(operand1);
            `EXU_OP_CLO:    alu_result = lead_zeros(~operand1);    // Leading ones of the inverse
            default:        alu_result = '0;
        endcase
    end

endmodule

// File: hdl/exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

`define EXU_DATA_W      32          // Data word width
`define EXU_ADDR_W      5           // Register file address width
`define EXU_OP_W        6           // Operator code width
`define EXU_SHAMT_W     5           // Shift amount taken from operand1

`define EXU_OP_SLL      6'h00
`define EXU_OP_SRL      6'h02
`define EXU_OP_SRA      6'h03
`define EXU_OP_ADDI     6'h08
`define EXU_OP_ADDIU    6'h09
`define EXU_OP_MFHI     6'h10
`define EXU_OP_MTHI     6'h11
`define EXU_OP_MFLO     6'h12
`define EXU_OP_MTLO     6'h13
`define EXU_OP_MULT     6'h18
`define EXU_OP_MULTU    6'h19
`define EXU_OP_DIV      6'h1a
`define EXU_OP_DIVU     6'h1b
`define EXU_OP_ADD      6'h20
`define EXU_OP_ADDU     6'h21
`define EXU_OP_SUB      6'h22
`define EXU_OP_SUBU     6'h23
`define EXU_OP_AND      6'h24
`define EXU_OP_OR       6'h25
`define EXU_OP_XOR      6'h26
`define EXU_OP_NOR      6'h27
`define EXU_OP_SLT      6'h2a
`define EXU_OP_SLTU     6'h2b
`define EXU_OP_CLZ      6'h3c       // Outside the funct space used above
`define EXU_OP_CLO      6'h3d

`define EXU_DIV_STEPS   32          // One quotient bit per iteration

`endif

// File: hdl/exu_ctrl.sv
`include "exu_cfg.svh"

module exu_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [`EXU_OP_W-1:0]    operator,
    input  logic [`EXU_DATA_W-1:0]  operand1,
    input  logic [`EXU_ADDR_W-1:0]  in_write_addr,
    input  logic                    in_write_enable,
    input  logic [`EXU_DATA_W-1:0]  alu_result,
    input  logic                    overflow,
    input  exu_pkg::hilo_word_t     mul_result,
    input  logic                    div_busy,
    input  logic                    div_done,
    input  exu_pkg::hilo_word_t     div_result,
    input  logic [`EXU_DATA_W-1:0]  hi,
    input  logic [`EXU_DATA_W-1:0]  lo,
    output logic                    in_ready,
    output logic                    div_start,
    output logic                    div_signed,
    output logic                    hilo_we,
    output exu_pkg::hilo_word_t     hilo_wdata,
    output logic                    out_valid,
    output logic [`EXU_ADDR_W-1:0]  write_addr,
    output logic                    write_enable,
    output logic [`EXU_DATA_W-1:0]  write_data
);

    logic                       accept;
    logic                       is_div;
    logic                       is_hilo_write;
    logic [`EXU_DATA_W-1:0]     result_sel;

    // Stall covers the whole division including its done cycle
    assign in_ready = !(div_busy || div_done);
    assign accept = in_valid && in_ready;

    assign is_div = (operator == `EXU_OP_DIV) || (operator == `EXU_OP_DIVU);
    assign is_hilo_write = (operator == `EXU_OP_MULT) || (operator == `EXU_OP_MULTU)
        || (operator == `EXU_OP_MTHI) || (operator == `EXU_OP_MTLO);

    assign div_start = accept && is_div;
    assign div_signed = accept && (operator == `EXU_OP_DIV);

    assign hilo_we = (accept && is_hilo_write) || div_done;

    // No op is accepted while div_done is high, so the division word wins there
    always_comb begin
        hilo_wdata = mul_result;
        if (div_done) begin
            hilo_wdata = div_result;
        end else if (operator == `EXU_OP_MTHI) begin
            hilo_wdata.halves.hi = operand1;
            hilo_wdata.halves.lo = lo;      // Keep the other half
        end else if (operator == `EXU_OP_MTLO) begin
            hilo_wdata.halves.hi = hi;
            hilo_wdata.halves.lo = operand1;
        end
    end

    always_comb begin
        case (operator)
            `EXU_OP_MFHI:   result_sel = hi;
            `EXU_OP_MFLO:   result_sel = lo;
            default:        result_sel = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            write_enable <= 1'b0;
        end else begin
            out_valid <= (accept && !is_div) || div_done;     // Division reports only at its end
            write_enable <= accept && !is_div && !is_hilo_write
                && in_write_enable && !overflow;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            write_addr <= in_write_addr;
            write_data <= result_sel;
        end
    end

    a_div_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (div_busy || div_done) |-> !out_valid)
        else $error("Output produced in the middle of a division");

endmodule

// File: hdl/exu_pkg.sv
`include "exu_cfg.svh"

package exu_pkg;

    // HI/LO as one 64-bit product or as a remainder/quotient pair
    typedef union packed {
        logic [2*`EXU_DATA_W-1:0] word;                 // Full product
        struct packed {
            logic [`EXU_DATA_W-1:0] hi;                 // Upper product half or remainder
            logic [`EXU_DATA_W-1:0] lo;                 // Lower product half or quotient
        } halves;
    } hilo_word_t;

endpackage

// File: hdl/exu_top.sv
`include "exu_cfg.svh"

module exu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [`EXU_OP_W-1:0]    operator,
    input  logic [`EXU_DATA_W-1:0]  operand1,
    input  logic [`EXU_DATA_W-1:0]  operand2,
    input  logic [`EXU_ADDR_W-1:0]  in_write_addr,
    input  logic                    in_write_enable,
    output logic                    in_ready,
    output logic                    out_valid,
    output logic [`EXU_ADDR_W-1:0]  write_addr,
    output logic                    write_enable,
    output logic [`EXU_DATA_W-1:0]  write_data
);

    logic [`EXU_DATA_W-1:0]     alu_result;
    logic                       overflow;
    exu_pkg::hilo_word_t        mul_result;
    exu_pkg::hilo_word_t        div_result;
    logic                       div_start;
    logic                       div_signed;
    logic                       div_busy;
    logic                       div_done;
    logic                       hilo_we;
    exu_pkg::hilo_word_t        hilo_wdata;
    logic [`EXU_DATA_W-1:0]     hi;
    logic [`EXU_DATA_W-1:0]     lo;

    alu_int alu_int_i (
        .operator       (operator),
        .operand1       (operand1),
        .operand2       (operand2),
        .alu_result     (alu_result),
        .overflow       (overflow)
    );

    muldiv_unit muldiv_unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .operator       (operator),
        .operand1       (operand1),
        .operand2       (operand2),
        .div_start      (div_start),
        .div_signed     (div_signed),
        .mul_result     (mul_result),
        .div_busy       (div_busy),
        .div_done       (div_done),
        .div_result     (div_result)
    );

    hilo_regs hilo_regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .hilo_we        (hilo_we),
        .hilo_wdata     (hilo_wdata),
        .hi             (hi),
        .lo             (lo)
    );

    exu_ctrl exu_ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .operator       (operator),
        .operand1       (operand1),
        .in_write_addr  (in_write_addr),
        .in_write_enable(in_write_enable),
        .alu_result     (alu_result),
        .overflow       (overflow),
        .mul_result     (mul_result),
        .div_busy       (div_busy),
        .div_done       (div_done),
        .div_result     (div_result),
        .hi             (hi),
        .lo             (lo),
        .in_ready       (in_ready),
        .div_start      (div_start),
        .div_signed     (div_signed),
        .hilo_we        (hilo_we),
        .hilo_wdata     (hilo_wdata),
        .out_valid      (out_valid),
        .write_addr     (write_addr),
        .write_enable   (write_enable),
        .write_data     (write_data)
    );

endmodule

// File: hdl/hilo_regs.sv
`include "exu_cfg.svh"

module hilo_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    hilo_we,
    input  exu_pkg::hilo_word_t     hilo_wdata,
    output logic [`EXU_DATA_W-1:0]  hi,
    output logic [`EXU_DATA_W-1:0]  lo
);

    // Both halves load together because the mthi/mtlo merge arrives already formed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (hilo_we) begin
            hi <= hilo_wdata.halves.hi;
            lo <= hilo_wdata.halves.lo;
        end
    end

    a_hilo_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({hi, lo}))
        else $error("HI/LO holds unknown bits");

endmodule

// File: hdl/muldiv_unit.sv
`include "exu_cfg.svh"

module muldiv_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`EXU_OP_W-1:0]    operator,
    input  logic [`EXU_DATA_W-1:0]  operand1,
    input  logic [`EXU_DATA_W-1:0]  operand2,
    input  logic                    div_start,
    input  logic                    div_signed,
    output exu_pkg::hilo_word_t     mul_result,
    output logic                    div_busy,
    output logic                    div_done,
    output exu_pkg::hilo_word_t     div_result
);

    localparam int W = `EXU_DATA_W;
    localparam int CNT_W = $clog2(`EXU_DIV_STEPS + 1);

    logic               mul_signed;
    logic               mul_neg;
    logic [2*W-1:0]     mul_a;
    logic [2*W-1:0]     mul_b;
    logic [2*W-1:0]     mul_mag;

    logic               start_dvd_neg;
    logic               start_dvs_neg;
    logic [W-1:0]       rem_q;
    logic [W-1:0]       quo_q;
    logic [W-1:0]       dvs_q;
    logic               dvd_neg_q;
    logic               quo_neg_q;
    logic               dvs_zero_q;
    logic [CNT_W-1:0]   cnt_q;
    logic [W:0]         rem_shift;
    logic [W:0]         trial;

    // Multiply magnitudes and restore the sign afterwards
    assign mul_signed = (operator == `EXU_OP_MULT);
    assign mul_a = {{W{1'b0}}, (mul_signed && operand1[W-1]) ? -operand1 : operand1};
    assign mul_b = {{W{1'b0}}, (mul_signed && operand2[W-1]) ? -operand2 : operand2};
    assign mul_mag = mul_a * mul_b;
    assign mul_neg = mul_signed && (operand1[W-1] ^ operand2[W-1]);
    assign mul_result.word = mul_neg ? -mul_mag : mul_mag;

    assign start_dvd_neg = div_signed && operand1[W-1];
    assign start_dvs_neg = div_signed && operand2[W-1];

    // Next dividend bit joins the partial remainder before the trial subtract
    assign rem_shift = {rem_q, quo_q[W-1]};
    assign trial = rem_shift - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_busy <= 1'b0;
            div_done <= 1'b0;
            cnt_q <= '0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                div_busy <= 1'b1;
                cnt_q <= '0;
            end else if (div_busy) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(`EXU_DIV_STEPS - 1)) begin
                    div_busy <= 1'b0;       // Last quotient bit lands on this edge
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            rem_q <= '0;
            quo_q <= start_dvd_neg ? -operand1 : operand1;  // Dividend shifts out as quotient fills
            dvs_q <= start_dvs_neg ? -operand2 : operand2;
            dvd_neg_q <= start_dvd_neg;
            quo_neg_q <= start_dvd_neg ^ start_dvs_neg;
            dvs_zero_q <= (operand2 == '0);
        end else if (div_busy) begin
            if (!trial[W]) begin
                rem_q <= trial[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
    end

    // Remainder follows the dividend sign, and a zero divisor leaves the dividend there
    always_comb begin
        div_result.halves.hi = dvd_neg_q ? -rem_q : rem_q;
        if (dvs_zero_q) begin
            div_result.halves.lo = '1;
        end else begin
            div_result.halves.lo = quo_neg_q ? -quo_q : quo_q;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        div_start |-> !div_busy)
        else $error("Divider restarted while busy");

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(div_busy) |-> ##(`EXU_DIV_STEPS) div_done)
        else $error("Divider finished off schedule");

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module exu_tb -o exu_sim \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/exu_sim 2>&1)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: sim.f
+incdir+hdl
+incdir+verif
hdl/exu_pkg.sv
hdl/alu_int.sv
hdl/muldiv_unit.sv
hdl/hilo_regs.sv
hdl/exu_ctrl.sv
hdl/exu_top.sv
verif/exu_tb.sv

// File: verif/exu_tb_cases.svh
`ifndef EXU_TB_CASES_SVH
`define EXU_TB_CASES_SVH

// Columns: operator, operand1, operand2, write address, write enable,
// expected write_data, expected write_enable, compare write_data
localparam int NUM_ROWS = 31;

case_row_t case_table [NUM_ROWS] = '{
    {`EXU_OP_AND,   32'hf0f01234, 32'h0ff0ff00, 5'd1,  1'b1, 32'h00f01200, 1'b1, 1'b1},
    {`EXU_OP_OR,    32'h00000001, 32'h00000002, 5'd2,  1'b0, 32'h00000003, 1'b0, 1'b1},
    {`EXU_OP_NOR,   32'hf0000000, 32'h0000000f, 5'd3,  1'b1, 32'h0ffffff0, 1'b1, 1'b1},
    {`EXU_OP_XOR,   32'haaaa5555, 32'hffff0000, 5'd4,  1'b1, 32'h55555555, 1'b1, 1'b1},
    {`EXU_OP_SLL,   32'h00000004, 32'h000000f1, 5'd5,  1'b1, 32'h00000f10, 1'b1, 1'b1},
    {`EXU_OP_SRL,   32'h00000008, 32'h80001200, 5'd6,  1'b1, 32'h00800012, 1'b1, 1'b1},
    {`EXU_OP_SRA,   32'h00000024, 32'h80000f00, 5'd7,  1'b1, 32'hf80000f0, 1'b1, 1'b1},
    {`EXU_OP_CLZ,   32'h00010000, 32'h00000000, 5'd8,  1'b1, 32'h0000000f, 1'b1, 1'b1},
    {`EXU_OP_CLO,   32'hfff00000, 32'h00000000, 5'd9,  1'b1, 32'h0000000c, 1'b1, 1'b1},
    {`EXU_OP_ADD,   32'h7fffffff, 32'h00000001, 5'd10, 1'b1, 32'h80000000, 1'b0, 1'b0},
    {`EXU_OP_ADDU,  32'h7fffffff, 32'h00000001, 5'd11, 1'b1, 32'h80000000, 1'b1, 1'b1},
    {`EXU_OP_SUB,   32'h80000000, 32'h00000001, 5'd12, 1'b1, 32'h7fffffff, 1'b0, 1'b0},
    {`EXU_OP_SLT,   32'hffffffff, 32'h00000001, 5'd13, 1'b1, 32'h00000001, 1'b1, 1'b1},
    {`EXU_OP_SLTU,  32'hffffffff, 32'h00000001, 5'd14, 1'b1, 32'h00000000, 1'b1, 1'b1},
    {`EXU_OP_MULT,  32'hfffffffe, 32'h00000003, 5'd15, 1'b1, 32'h00000000, 1'b0, 1'b0},
    {`EXU_OP_MFHI,  32'h00000000, 32'h00000000, 5'd16, 1'b1, 32'hffffffff, 1'b1, 1'b1},
    {`EXU_OP_MFLO,  32'h00000000, 32'h00000000, 5'd17, 1'b1, 32'hfffffffa, 1'b1, 1'b1},
    {`EXU_OP_MULTU, 32'hfffffffe, 32'hfffffffd, 5'd18, 1'b1, 32'h00000000, 1'b0, 1'b0},
    {`EXU_OP_MFHI,  32'h00000000, 32'h00000000, 5'd19, 1'b1, 32'hfffffffb, 1'b1, 1'b1},
    {`EXU_OP_MFLO,  32'h00000000, 32'h00000000, 5'd20, 1'b1, 32'h00000006, 1'b1, 1'b1},
    {`EXU_OP_MTHI,  32'h12345678, 32'h00000000, 5'd21, 1'b1, 32'h00000000, 1'b0, 1'b0},
    {`EXU_OP_MFLO,  32'h00000000, 32'h00000000, 5'd22, 1'b1, 32'h00000006, 1'b1, 1'b1},
    {`EXU_OP_MTLO,  32'h87654321, 32'h00000000, 5'd23, 1'b1, 32'h00000000, 1'b0, 1'b0},
    {`EXU_OP_MFHI,  32'h00000000, 32'h00000000, 5'd24, 1'b1, 32'h12345678, 1'b1, 1'b1},
    {`EXU_OP_MFLO,  32'h00000000, 32'h00000000, 5'd31, 1'b1, 32'h87654321, 1'b1, 1'b1},
    {`EXU_OP_DIV,   32'hfffffff9, 32'h00000002, 5'd25, 1'b1, 32'h00000000, 1'b0, 1'b0},
    {`EXU_OP_MFHI,  32'h00000000, 32'h00000000, 5'd26, 1'b1, 32'hffffffff, 1'b1, 1'b1},
    {`EXU_OP_MFLO,  32'h00000000, 32'h00000000, 5'd27, 1'b1, 32'hfffffffd, 1'b1, 1'b1},
    {`EXU_OP_DIVU,  32'hfffffff9, 32'h00000000, 5'd28, 1'b1, 32'h00000000, 1'b0, 1'b0},
    {`EXU_OP_MFHI,  32'h00000000, 32'h00000000, 5'd29, 1'b1, 32'hfffffff9, 1'b1, 1'b1},
    {`EXU_OP_MFLO,  32'h00000000, 32'h00000000, 5'd30, 1'b1, 32'hffffffff, 1'b1, 1'b1}
};

`endif

// File: verif/exu_tb.sv
`include "exu_cfg.svh"

module exu_tb;

    localparam int RAND_PAIRS = 40;

    typedef struct packed {
        logic [`EXU_OP_W-1:0]   op;
        logic [`EXU_DATA_W-1:0] a;
        logic [`EXU_DATA_W-1:0] b;
        logic [`EXU_ADDR_W-1:0] waddr;
        logic                   wen;
        logic [`EXU_DATA_W-1:0] exp_data;
        logic                   exp_wen;
        logic                   chk_data;           // Result word is defined for this operator
    } case_row_t;

    `include "exu_tb_cases.svh"

    localparam int CYCLE_LIMIT = NUM_ROWS * (`EXU_DIV_STEPS + 4) + RAND_PAIRS * 8;

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    logic [`EXU_OP_W-1:0]       operator;
    logic [`EXU_DATA_W-1:0]     operand1;
    logic [`EXU_DATA_W-1:0]     operand2;
    logic [`EXU_ADDR_W-1:0]     in_write_addr;
    logic                       in_write_enable;
    logic                       in_ready;
    logic                       out_valid;
    logic [`EXU_ADDR_W-1:0]     write_addr;
    logic                       write_enable;
    logic [`EXU_DATA_W-1:0]     write_data;

    case_row_t                  expect_q [$];       // Accepted operations still waiting for out_valid
    logic [15:0]                lfsr_state;
    int                         cycle_count;

    exu_top exu_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .operator       (operator),
        .operand1       (operand1),
        .operand2       (operand2),
        .in_write_addr  (in_write_addr),
        .in_write_enable(in_write_enable),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .write_addr     (write_addr),
        .write_enable   (write_enable),
        .write_data     (write_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic case_row_t make_row(input logic [`EXU_OP_W-1:0] op,
                                           input logic [31:0] a, input logic [31:0] b,
                                           input logic [4:0] waddr, input logic [31:0] exp);
        return {op, a, b, waddr, 1'b1, exp, 1'b1, 1'b1};
    endfunction

    // Drives one operation and returns once it is sure to be taken at the next edge
    task automatic send_op(input case_row_t row);
        @(posedge clk);
        in_valid <= 1'b1;
        operator <= row.op;
        operand1 <= row.a;
        operand2 <= row.b;
        in_write_addr <= row.waddr;
        in_write_enable <= row.wen;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        expect_q.push_back(row);
    endtask

    initial begin : output_monitor
        case_row_t row;
        forever begin
            @(negedge clk);
            if (rst_n && out_valid) begin
                if (expect_q.size() == 0) begin
                    $display("out_valid rose with no operation outstanding");
                    $display("CHECKS FAILED");
                    $fatal(1, "Unexpected result from the DUT");
                end else begin
                    row = expect_q.pop_front();
                    check_value("write_enable", 32'(write_enable), 32'(row.exp_wen));
                    check_value("write_addr", 32'(write_addr), 32'(row.waddr));
                    if (row.chk_data) begin
                        check_value("write_data", write_data, row.exp_data);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("CHECKS FAILED");
        $fatal(1, "Run did not finish within %0d cycles", CYCLE_LIMIT);
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        rst_n <= 1'b0;
        in_valid <= 1'b0;
        operator <= '0;
        operand1 <= '0;
        operand2 <= '0;
        in_write_addr <= '0;
        in_write_enable <= 1'b0;
        lfsr_state = 16'd43988;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_op(case_table[i]);
        end
        for (int k = 0; k < RAND_PAIRS; k++) begin
            draw_word(a);
            draw_word(b);
            send_op(make_row(`EXU_OP_AND, a, b, 5'(k), a & b));
            send_op(make_row(`EXU_OP_XOR, a, b, 5'(k), a ^ b));
            send_op(make_row(`EXU_OP_ADDU, a, b, 5'(k), a + b));
            send_op(make_row(`EXU_OP_SLTU, a, b, 5'(k), {31'd0, a < b}));
        end
        @(posedge clk);
        in_valid <= 1'b0;                           // Last operation is taken on this edge
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);                             // The stage must stay quiet once drained
        if (!out_valid) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "out_valid rose after the last expected result");
        end
    end

endmodule
